//--- spi_cmd_consts.svh
`ifndef SPI_CMD_CONSTS_SVH
`define SPI_CMD_CONSTS_SVH

// datapath widths
`define BYTE_W      8
`define WORD_W      16
`define RAM_AW      8

// addresses at or above this are out of range
`define RAM_DEPTH   256

// opcodes, first byte of a frame
`define OP_DISABLE  8'h00
`define OP_ENABLE   8'h01
`define OP_WR_REG   8'h02
`define OP_RD_REG   8'h03
`define OP_WR_RAM   8'h06
`define OP_RD_RAM   8'h07

// register map
`define REG_SUM     8'd0
`define REG_NUM1    8'd1
`define REG_NUM2    8'd2
`define REG_NUM3    8'd3
`define REG_EN      8'd4

`endif

//--- spi_cmd_pkg.sv
`include "spi_cmd_consts.svh"

package spi_cmd_pkg;

    typedef struct packed {
        logic               valid;
        logic [`BYTE_W-1:0] data;
    } rx_byte_t;

    typedef struct packed {
        logic               valid;
        logic [`BYTE_W-1:0] addr;
        logic [`WORD_W-1:0] data;
    } reg_wr_t;

    typedef struct packed {
        logic               valid;
        logic [`RAM_AW-1:0] addr;
        logic [`WORD_W-1:0] data;
    } ram_wr_t;

    // one state per expected byte of a frame
    typedef enum logic [3:0] {
        ST_IDLE, ST_OPCODE, ST_REG_ADDR, ST_REG_HI, ST_REG_LO,
        ST_RD_HI, ST_RD_LO, ST_ADDR_HI, ST_ADDR_LO, ST_CNT_HI,
        ST_CNT_LO, ST_WORD_HI, ST_WORD_LO, ST_IGNORE
    } frame_state_e;

endpackage

//--- spi_byte_shifter.sv
`timescale 1ns/1ps
`include "spi_cmd_consts.svh"

module spi_byte_shifter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  spi_scl,
    input  logic                  spi_sdi,
    input  logic                  spi_sel,
    input  logic [`BYTE_W-1:0]    tx_byte,
    output logic                  spi_sdo,
    output spi_cmd_pkg::rx_byte_t rx,
    output logic                  tx_req,
    output logic                  sel_active
);

    logic [2:0]          scl_q;
    logic [2:0]          sel_q;
    logic [1:0]          sdi_q;
    logic [2:0]          bit_cnt;
    logic [`BYTE_W-2:0]  rx_shift;
    logic [`BYTE_W-1:0]  tx_shift;
    logic                req_d;
    logic                scl_rise;
    logic                scl_fall;
    logic                sel_fall;

    // [1] is the synchronized pin, [2] is one cycle older
    assign scl_rise   = scl_q[1] & ~scl_q[2];
    assign scl_fall   = ~scl_q[1] & scl_q[2];
    assign sel_fall   = ~sel_q[1] & sel_q[2];
    assign sel_active = ~sel_q[1];
    assign spi_sdo    = tx_shift[`BYTE_W-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scl_q <= '0;
            sel_q <= '1;
            sdi_q <= '0;
        end else begin
            scl_q <= {scl_q[1:0], spi_scl};
            sel_q <= {sel_q[1:0], spi_sel};
            sdi_q <= {sdi_q[0], spi_sdi};
        end
    end

    always_ff @(posedge clk) begin
        if (scl_rise) begin
            rx_shift <= {rx_shift[`BYTE_W-3:0], sdi_q[1]};
        end
    end

    // msb first, byte done on the eighth rising edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt <= '0;
            rx      <= '0;
        end else begin
            rx.valid <= 1'b0;
            if (!sel_active) begin
                bit_cnt <= '0;
            end else if (scl_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    rx <= '{valid: 1'b1, data: {rx_shift, sdi_q[1]}};
                end
            end
        end
    end

    // the falling edge after the last bit would eat the new msb, so skip it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_d    <= 1'b0;
            tx_req   <= 1'b0;
            tx_shift <= '0;
        end else begin
            req_d  <= rx.valid | sel_fall;
            tx_req <= req_d;
            if (tx_req) begin
                tx_shift <= tx_byte;
            end else if (scl_fall && bit_cnt != 3'd0) begin
                tx_shift <= {tx_shift[`BYTE_W-2:0], 1'b0};
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(rx.valid && tx_req));

endmodule

//--- reg_bank.sv
`timescale 1ns/1ps
`include "spi_cmd_consts.svh"

module reg_bank (
    input  logic                 clk,
    input  logic                 rst_n,
    input  spi_cmd_pkg::reg_wr_t reg_wr,
    input  logic                 en_set,
    input  logic                 en_clr,
    input  logic [`BYTE_W-1:0]   reg_raddr,
    input  logic [`WORD_W-1:0]   sum,
    output logic [`WORD_W-1:0]   reg_rdata,
    output logic [`WORD_W-1:0]   num1,
    output logic [`WORD_W-1:0]   num2,
    output logic [`WORD_W-1:0]   num3,
    output logic                 en
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            num1 <= '0;
            num2 <= '0;
            num3 <= '0;
            en   <= 1'b0;
        end else begin
            // sum is read only, unknown addresses drop the write
            if (reg_wr.valid) begin
                case (reg_wr.addr)
                    `REG_NUM1: num1 <= reg_wr.data;
                    `REG_NUM2: num2 <= reg_wr.data;
                    `REG_NUM3: num3 <= reg_wr.data;
                    default:   ;
                endcase
            end
            if (en_set) begin
                en <= 1'b1;
            end else if (en_clr) begin
                en <= 1'b0;
            end
        end
    end

    always_comb begin
        case (reg_raddr)
            `REG_SUM:  reg_rdata = sum;
            `REG_NUM1: reg_rdata = num1;
            `REG_NUM2: reg_rdata = num2;
            `REG_NUM3: reg_rdata = num3;
            `REG_EN:   reg_rdata = {{(`WORD_W-1){1'b0}}, en};
            default:   reg_rdata = '0;
        endcase
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(en_set && en_clr));

endmodule

//--- cmd_parser.sv
`timescale 1ns/1ps
`include "spi_cmd_consts.svh"

module cmd_parser (
    input  logic                  clk,
    input  logic                  rst_n,
    input  spi_cmd_pkg::rx_byte_t rx,
    input  logic                  tx_req,
    input  logic                  sel_active,
    input  logic [`WORD_W-1:0]    reg_rdata,
    input  logic [`WORD_W-1:0]    ram_rdata,
    output logic [`BYTE_W-1:0]    tx_byte,
    output spi_cmd_pkg::reg_wr_t  reg_wr,
    output logic [`BYTE_W-1:0]    reg_raddr,
    output logic                  en_set,
    output logic                  en_clr,
    output spi_cmd_pkg::ram_wr_t  ram_wr,
    output logic [`RAM_AW-1:0]    ram_raddr
);
    import spi_cmd_pkg::*;

    frame_state_e        state;
    logic                rd_cmd;
    logic [`WORD_W-1:0]  addr;
    logic [`WORD_W-1:0]  cnt;
    logic [`WORD_W-1:0]  reply;
    logic [`BYTE_W-1:0]  hold;
    logic [`WORD_W-1:0]  addr_nxt;
    logic                addr_ok;
    logic                next_ok;
    logic                last_word;

    assign addr_nxt  = addr + 1'b1;
    assign addr_ok   = addr < `WORD_W'(`RAM_DEPTH);
    assign next_ok   = addr_nxt < `WORD_W'(`RAM_DEPTH);
    // count of 0 behaves as 1
    assign last_word = cnt < `WORD_W'(2);
    assign reg_raddr = rx.data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            rd_cmd    <= 1'b0;
            reg_wr    <= '0;
            ram_wr    <= '0;
            en_set    <= 1'b0;
            en_clr    <= 1'b0;
            ram_raddr <= '0;
        end else begin
            reg_wr.valid <= 1'b0;
            ram_wr.valid <= 1'b0;
            en_set       <= 1'b0;
            en_clr       <= 1'b0;
            if (!sel_active) begin
                state <= ST_IDLE;
            end else if (state == ST_IDLE) begin
                state <= ST_OPCODE;
            end else if (rx.valid) begin
                case (state)
                    ST_OPCODE: begin
                        rd_cmd <= (rx.data == `OP_RD_REG) || (rx.data == `OP_RD_RAM);
                        en_set <= rx.data == `OP_ENABLE;
                        en_clr <= rx.data == `OP_DISABLE;
                        case (rx.data)
                            `OP_WR_REG, `OP_RD_REG: state <= ST_REG_ADDR;
                            `OP_WR_RAM, `OP_RD_RAM: state <= ST_ADDR_HI;
                            default:                state <= ST_IGNORE;
                        endcase
                    end
                    ST_REG_ADDR: state <= rd_cmd ? ST_RD_HI : ST_REG_HI;
                    ST_REG_HI:   state <= ST_REG_LO;
                    ST_REG_LO: begin
                        reg_wr <= '{valid: 1'b1, addr: addr[`BYTE_W-1:0],
                                    data: {hold, rx.data}};
                        state  <= ST_IGNORE;
                    end
                    ST_RD_HI:    state <= ST_RD_LO;
                    ST_RD_LO:    state <= ST_IGNORE;
                    ST_ADDR_HI:  state <= ST_ADDR_LO;
                    ST_ADDR_LO:  state <= ST_CNT_HI;
                    ST_CNT_HI:   state <= ST_CNT_LO;
                    ST_CNT_LO: begin
                        // first read address goes out before the first reply
                        if (rd_cmd) begin
                            ram_raddr <= addr_ok ? addr[`RAM_AW-1:0] : '0;
                        end
                        state <= ST_WORD_HI;
                    end
                    ST_WORD_HI:  state <= ST_WORD_LO;
                    ST_WORD_LO: begin
                        if (rd_cmd) begin
                            ram_raddr <= next_ok ? addr_nxt[`RAM_AW-1:0] : '0;
                        end else begin
                            ram_wr <= '{valid: addr_ok, addr: addr[`RAM_AW-1:0],
                                        data: {hold, rx.data}};
                        end
                        state <= last_word ? ST_IGNORE : ST_WORD_HI;
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx.valid) begin
            case (state)
                ST_REG_ADDR: begin
                    addr  <= {{(`WORD_W-`BYTE_W){1'b0}}, rx.data};
                    reply <= reg_rdata;
                end
                ST_REG_HI, ST_WORD_HI: hold <= rx.data;
                ST_ADDR_HI: addr[`WORD_W-1:`BYTE_W] <= rx.data;
                ST_ADDR_LO: addr[`BYTE_W-1:0] <= rx.data;
                ST_CNT_HI:  cnt[`WORD_W-1:`BYTE_W] <= rx.data;
                ST_CNT_LO:  cnt[`BYTE_W-1:0] <= rx.data;
                ST_WORD_LO: begin
                    addr <= addr_nxt;
                    cnt  <= cnt - 1'b1;
                end
                default: ;
            endcase
        end
    end

    // reply for the byte the master clocks next
    always_comb begin
        tx_byte = '0;
        if (tx_req) begin
            case (state)
                ST_RD_HI:   tx_byte = reply[`WORD_W-1:`BYTE_W];
                ST_RD_LO:   tx_byte = reply[`BYTE_W-1:0];
                ST_WORD_HI: tx_byte = (rd_cmd && addr_ok) ? ram_rdata[`WORD_W-1:`BYTE_W] : '0;
                ST_WORD_LO: tx_byte = (rd_cmd && addr_ok) ? ram_rdata[`BYTE_W-1:0] : '0;
                default:    tx_byte = '0;
            endcase
        end
    end

    // strobe address is the full frame address, untruncated and below the ram depth
    assert property (@(posedge clk) disable iff (!rst_n)
        ram_wr.valid |-> $past(addr) == `WORD_W'(ram_wr.addr)
                         && `WORD_W'(ram_wr.addr) < `WORD_W'(`RAM_DEPTH));

endmodule

//--- spi_cmd_bridge.sv
`timescale 1ns/1ps
`include "spi_cmd_consts.svh"

module spi_cmd_bridge (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 spi_scl,
    input  logic                 spi_sdi,
    input  logic                 spi_sel,
    output logic                 spi_sdo,
    input  logic [`WORD_W-1:0]   sum,
    output logic [`WORD_W-1:0]   num1,
    output logic [`WORD_W-1:0]   num2,
    output logic [`WORD_W-1:0]   num3,
    output logic                 en,
    output spi_cmd_pkg::ram_wr_t ram_wr,
    output logic [`RAM_AW-1:0]   ram_raddr,
    input  logic [`WORD_W-1:0]   ram_rdata
);
    import spi_cmd_pkg::*;

    // shifter and parser
    rx_byte_t            rx;
    logic                tx_req;
    logic                sel_active;
    logic [`BYTE_W-1:0]  tx_byte;

    // parser and register bank
    reg_wr_t             reg_wr;
    logic [`BYTE_W-1:0]  reg_raddr;
    logic [`WORD_W-1:0]  reg_rdata;
    logic                en_set;
    logic                en_clr;

    spi_byte_shifter spi_byte_shifter_inst (.*);

    cmd_parser cmd_parser_inst (.*);

    reg_bank reg_bank_inst (.*);

endmodule

//--- tb_spi_tasks.svh
// spi master timing in clk cycles
localparam int HALF_SCL = 8;
localparam int BYTE_GAP = 10;

task automatic step_clk(input int n);
    repeat (n) @(posedge clk);
    #2;
endtask

// one-cycle strobe for the output assertion
task automatic check_outputs();
    out_chk = 1'b1;
    step_clk(1);
    out_chk = 1'b0;
endtask

task automatic add_word(input logic [`WORD_W-1:0] w);
    frame_q.push_back(w[`WORD_W-1:`BYTE_W]);
    frame_q.push_back(w[`BYTE_W-1:0]);
endtask

// mode 0, msb first, sdo sampled on the rising scl edge
task automatic spi_byte(input logic [`BYTE_W-1:0] tx_b);
    logic [`BYTE_W-1:0] rx_b;
    for (int i = `BYTE_W - 1; i >= 0; i--) begin
        spi_sdi = tx_b[i];
        step_clk(HALF_SCL);
        spi_scl = 1'b1;
        rx_b[i] = spi_sdo;
        step_clk(HALF_SCL);
        spi_scl = 1'b0;
    end
    reply_q.push_back(rx_b);
    step_clk(BYTE_GAP);
endtask

task automatic send_frame();
    reply_q.delete();
    spi_sel = 1'b0;
    step_clk(BYTE_GAP);
    foreach (frame_q[i]) begin
        spi_byte(frame_q[i]);
    end
    spi_sel = 1'b1;
    frame_q.delete();
    step_clk(BYTE_GAP);
    check_outputs();
endtask

//--- tb_spi_cmd_bridge.sv
`timescale 1ns/1ps
`include "spi_cmd_consts.svh"

module tb_spi_cmd_bridge;
    import spi_cmd_pkg::*;

    // roughly twice the cycles of the whole run
    localparam int MAX_CYCLES = 40000;

    logic               clk;
    logic               rst_n;
    logic               spi_scl;
    logic               spi_sdi;
    logic               spi_sel;
    logic               spi_sdo;
    logic [`WORD_W-1:0] sum;
    logic [`WORD_W-1:0] num1;
    logic [`WORD_W-1:0] num2;
    logic [`WORD_W-1:0] num3;
    logic               en;
    ram_wr_t            ram_wr;
    logic [`RAM_AW-1:0] ram_raddr;
    logic [`WORD_W-1:0] ram_rdata;

    logic [`WORD_W-1:0] ram_mem [`RAM_DEPTH];
    logic [`WORD_W-1:0] exp_mem [`RAM_DEPTH];
    logic [`WORD_W-1:0] exp_num1;
    logic [`WORD_W-1:0] exp_num2;
    logic [`WORD_W-1:0] exp_num3;
    logic               exp_en;
    ram_wr_t            exp_wr_q[$];
    logic [`BYTE_W-1:0] frame_q[$];
    logic [`BYTE_W-1:0] reply_q[$];
    logic               out_chk;
    int                 wr_left;
    int                 errors;
    int                 cycles;
    int                 base;

    spi_cmd_bridge spi_cmd_bridge_inst (.*);

    `include "tb_spi_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // synchronous-read ram behind the bridge
    always @(posedge clk) begin
        if (ram_wr.valid) begin
            ram_mem[ram_wr.addr] <= ram_wr.data;
        end
        ram_rdata <= ram_mem[ram_raddr];
    end

    always @(posedge clk) begin
        cycles++;
        if (rst_n && ram_wr.valid && wr_left > 0) begin
            assert (ram_wr === exp_wr_q[0]) else begin
                errors++;
                $display("[ERROR] ram_wr got 0x%h expected 0x%h", ram_wr, exp_wr_q[0]);
            end
            void'(exp_wr_q.pop_front());
            wr_left--;
        end
        if (cycles >= MAX_CYCLES) begin
            $display("timeout, run still busy after %0d cycles", cycles);
            $display("errors: %0d", errors);
            $display("test failed");
            $finish;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) ram_wr.valid |-> wr_left > 0)
        else begin
            errors++;
            $display("unexpected ram_wr strobe at address 0x%h", $sampled(ram_wr.addr));
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        out_chk |-> {num1, num2, num3, en} == {exp_num1, exp_num2, exp_num3, exp_en})
        else begin
            errors++;
            $display("[ERROR] num1 num2 num3 en got 0x%h 0x%h 0x%h 0x%h",
                     $sampled(num1), $sampled(num2), $sampled(num3), $sampled(en));
            $display("[ERROR] num1 num2 num3 en expected 0x%h 0x%h 0x%h 0x%h",
                     exp_num1, exp_num2, exp_num3, exp_en);
        end

    task automatic expect_word(input string name, input logic [15:0] got,
                               input logic [15:0] want);
        assert (got === want) else begin
            errors++;
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, want);
        end
    endtask

    task automatic write_reg(input logic [`BYTE_W-1:0] addr, input logic [`WORD_W-1:0] data);
        frame_q.push_back(`OP_WR_REG);
        frame_q.push_back(addr);
        add_word(data);
        send_frame();
    endtask

    // reply bytes 2 and 3 carry the word latched at the address byte
    task automatic read_reg(input logic [`BYTE_W-1:0] addr, input logic [`WORD_W-1:0] want);
        frame_q.push_back(`OP_RD_REG);
        frame_q.push_back(addr);
        add_word(16'h0000);
        send_frame();
        expect_word($sformatf("spi_sdo reg %0d", addr), {reply_q[2], reply_q[3]}, want);
    endtask

    task automatic burst_write(input int start, input int count);
        logic [`WORD_W-1:0] data;
        frame_q.push_back(`OP_WR_RAM);
        add_word(16'(start));
        add_word(16'(count));
        for (int i = 0; i < count; i++) begin
            data = 16'($urandom());
            add_word(data);
            // no strobe past the end of the ram
            if (start + i < `RAM_DEPTH) begin
                exp_wr_q.push_back({1'b1, `RAM_AW'(start + i), data});
                exp_mem[start + i] = data;
                wr_left++;
            end
        end
        send_frame();
        if (wr_left != 0) begin
            errors++;
            $display("%0d ram_wr strobes missing after burst at 0x%h", wr_left, start);
            wr_left = 0;
            exp_wr_q.delete();
        end
    endtask

    task automatic burst_read(input int start, input int count);
        logic [`WORD_W-1:0] want;
        frame_q.push_back(`OP_RD_RAM);
        add_word(16'(start));
        add_word(16'(count));
        for (int i = 0; i < count; i++) begin
            add_word(16'h0000);
        end
        send_frame();
        // words follow the five header bytes
        for (int i = 0; i < count; i++) begin
            want = (start + i < `RAM_DEPTH) ? exp_mem[start + i] : '0;
            expect_word($sformatf("spi_sdo ram word 0x%h", start + i),
                        {reply_q[5 + 2 * i], reply_q[6 + 2 * i]}, want);
        end
    endtask

    initial begin
        void'($urandom(87));
        rst_n   = 1'b0;
        spi_scl = 1'b0;
        spi_sdi = 1'b0;
        spi_sel = 1'b1;
        out_chk = 1'b0;
        sum     = 16'($urandom());
        {exp_num1, exp_num2, exp_num3, exp_en} = '0;
        ram_rdata <= '0;
        // fill pattern uses every address bit
        for (int a = 0; a < `RAM_DEPTH; a++) begin
            ram_mem[a] <= 16'hc3a5 ^ {a[7:0], ~a[7:0]};
            exp_mem[a] = 16'hc3a5 ^ {a[7:0], ~a[7:0]};
        end
        step_clk(2);
        rst_n = 1'b1;
        step_clk(4);
        check_outputs();

        frame_q.push_back(`OP_ENABLE);
        exp_en = 1'b1;
        send_frame();
        frame_q.push_back(`OP_DISABLE);
        exp_en = 1'b0;
        send_frame();
        frame_q.push_back(`OP_ENABLE);
        exp_en = 1'b1;
        send_frame();
        // trailing bytes look like commands and must be ignored
        for (int k = 0; k < 3; k++) begin
            frame_q.push_back(k == 2 ? 8'h09 : 8'(4 + k));
            frame_q.push_back(`OP_DISABLE);
            frame_q.push_back(`OP_WR_RAM);
            send_frame();
        end

        exp_num1 = 16'($urandom());
        write_reg(`REG_NUM1, exp_num1);
        exp_num2 = 16'($urandom());
        write_reg(`REG_NUM2, exp_num2);
        exp_num3 = 16'($urandom());
        write_reg(`REG_NUM3, exp_num3);
        write_reg(`REG_SUM, 16'($urandom()));
        write_reg(8'd7, 16'($urandom()));

        read_reg(`REG_SUM, sum);
        read_reg(`REG_NUM1, exp_num1);
        read_reg(`REG_NUM2, exp_num2);
        read_reg(`REG_NUM3, exp_num3);
        read_reg(`REG_EN, {15'd0, exp_en});
        read_reg(8'd9, 16'h0000);

        base = $urandom_range(200);
        burst_write(base, 8);
        burst_write(254, 4);
        burst_read(base, 8);
        burst_read(254, 4);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+.
spi_cmd_pkg.sv
spi_byte_shifter.sv
reg_bank.sv
cmd_parser.sv
spi_cmd_bridge.sv
tb_spi_cmd_bridge.sv

//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
TOP        := tb_spi_cmd_bridge
RTL_TOP    := spi_cmd_bridge
FILELIST   := files.f
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	@grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
